// File: src.f
+incdir+sim
hw/ptwPkg.sv
hw/ptwAddrGen.sv
hw/ptwPteCheck.sv
hw/ptwWalker.sv
hw/ptw.sv
sim/ptwTb.sv

// File: Makefile
# Verilator build and run of the page table walker testbench

SIM  = obj_dir/VptwTb
SRCS = $(wildcard hw/*.sv sim/*.sv sim/*.svh)

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q '^Test OK$$'

# Rebuilt only when a source or the file list changes
$(SIM): src.f $(SRCS)
	verilator --binary --assert -f src.f --top-module ptwTb --Mdir obj_dir -o VptwTb

clean:
	rm -rf obj_dir

// File: sim/ptwTbTables.svh
// Page table construction in the memory model
// Expected walk result derived from the Sv39 rules
`ifndef PTW_TB_TABLES_SVH
`define PTW_TB_TABLES_SVH

localparam logic [43:0] RootPpn = 44'h80000;  // Root table, further tables follow it

// Sign extend a 39 bit address into a canonical VA
function automatic logic [63:0] makeVa(input logic [38:0] low);
  return {{25{low[38]}}, low};
endfunction

function automatic logic [63:0] makePte(input logic [43:0] ppn, input logic [7:0] flags);
  return {10'b0, ppn, 2'b00, flags};  // No PBMT, RSW clear
endfunction

// Result kind of the entry that ends a walk at level lvl
function automatic int classify(input logic [63:0] e, input int lvl, input accessType_t acc);
  logic v, r, w, x, a, d;
  logic misaligned;
  logic permOk;
  {d, a} = e[7:6];
  {x, w, r, v} = e[3:0];
  if (!v || (w && !r)) return KindPage;  // Invalid entry
  // A final pointer is either reserved or at level 0, both faults
  if (!(r || w || x)) return KindPage;
  misaligned = (lvl == 2) ? (|e[27:10]) : ((lvl == 1) ? (|e[18:10]) : 1'b0);
  case (acc)
    accLoad:  permOk = r;
    accStore: permOk = w;
    default:  permOk = x;
  endcase
  if (misaligned || !permOk || !a) return KindPage;
  if (acc == accStore && !d) return KindPage;  // Dirty bit is software managed
  return KindWrite;
endfunction

// Pointer chain from the root down to lvl, entry placed at lvl
task automatic buildWalk(input logic [63:0] va, input int lvl, input logic [63:0] entry,
                         input accessType_t acc);
  logic [43:0] tblPpn;
  tblPpn = RootPpn;
  mem.delete();
  expAdr.delete();
  faultArmed = 1'b0;
  for (int l = 2; l >= lvl; l--) begin
    logic [55:0] adr;
    adr = {tblPpn, va[12 + 9 * l +: 9], 3'b000};
    expAdr.push_back(adr);
    if (l == lvl) mem[adr] = entry;
    else mem[adr] = makePte(tblPpn + 44'd1, 8'h01);  // Plain pointer, V only
    tblPpn = tblPpn + 44'd1;
  end
  expKind = classify(entry, lvl, acc);
  expPte  = entry;
  expType = level_t'(lvl);
  if (va[63:39] != {25{va[38]}}) begin
    expKind = KindPage;  // Rejected before any table read
    expAdr.delete();
  end
endtask

// Memory answers the idx-th table read with an access fault
task automatic breakRead(input int idx);
  faultAdr   = expAdr[idx];
  faultArmed = 1'b1;
  while (expAdr.size() > idx + 1) void'(expAdr.pop_back());
  expKind = KindAccess;
endtask

`endif

// File: sim/ptwTb.sv
// Testbench for the Sv39 page table walker
// Clock, reset, memory model with random stalls, walk sequences and checks
`default_nettype none

module ptwTb import ptwPkg::*; ();

  localparam int KindWrite  = 0;  // tlbWrite
  localparam int KindPage   = 1;  // pageFault
  localparam int KindAccess = 2;  // accessFault
  localparam int NumWalks   = 40;  // Two suites of 19 plus the flush pair
  localparam int CycleLimit = 40 * NumWalks;

  logic               clk;
  logic               arstN;
  logic               flush;
  logic               tlbMiss;
  logic               memStall       = 1'b0;
  logic               memAccessFault = 1'b0;
  logic [PteBits-1:0] vAdr;
  logic [PteBits-1:0] memRdData      = '0;
  logic [PpnBits-1:0] satpPpn;
  accessType_t        accessType;
  logic [55:0]        memAdr;
  logic               memRead;
  logic               busy;
  logic               tlbWrite;
  logic               pageFault;
  logic               accessFault;
  logic [PteBits-1:0] pte;
  level_t             pageType;

  // Memory model state and expected results
  logic [PteBits-1:0] mem [logic [55:0]];
  logic [55:0]        expAdr [$];  // Table reads still to come, in order
  int                 expKind;
  logic [PteBits-1:0] expPte;
  level_t             expType;
  logic               faultArmed;
  logic [55:0]        faultAdr;
  logic               stallOn;
  logic               reading    = 1'b0;
  int                 stallLeft  = 0;
  logic               missAtEdge = 1'b0;  // tlbMiss as seen by the last rising edge
  logic [31:0]        lfsr       = 32'hbfcc;
  int                 cycles     = 0;
  string              testName   = "reset";

  `include "ptwTbTables.svh"

  ptw #(.PaBits(56)) dut (.*);  // Port names match one to one

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] takeBits(input int n);
    logic [63:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      val  = {val[62:0], lfsr[0]};
    end
    return val;
  endfunction

  task automatic stopRun(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic failValue(input string what, input logic [63:0] expVal,
                           input logic [63:0] actVal);
    stopRun($sformatf("[FAIL] %s %s expected %h actual %h", testName, what, expVal, actVal));
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // Memory model
  ////////////////////
  always @(negedge clk) begin
    logic [55:0] adr;
    if (!memRead) begin
      reading        = 1'b0;
      memStall       = 1'b0;
      memAccessFault = 1'b0;
    end else begin
      if (!reading) begin  // First cycle of a read
        reading   = 1'b1;
        stallLeft = stallOn ? int'(takeBits(2)) : 0;
        if (expAdr.size() == 0) begin
          stopRun($sformatf("Unexpected table read in %s", testName));
        end else begin
          adr = expAdr.pop_front();
          assert (memAdr == adr) else failValue("memAdr", 64'(adr), 64'(memAdr));
        end
      end else if (stallLeft != 0) begin
        stallLeft--;
      end
      memStall       = (stallLeft != 0);
      memRdData      = mem.exists(memAdr) ? mem[memAdr] : '0;
      memAccessFault = faultArmed && (memAdr == faultAdr);
    end
  end

  // Results only answer a pending miss
  always @(posedge clk) missAtEdge <= tlbMiss;
  always @(negedge clk) begin
    assert (missAtEdge || !(tlbWrite || pageFault || accessFault))
      else stopRun($sformatf("Result pulse with no TLB miss pending in %s", testName));
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CycleLimit) stopRun("Timeout with walks still unfinished");
  end

  ////////////////////
  // Walk sequences
  ////////////////////
  task automatic runWalk(input logic [63:0] va, input accessType_t acc);
    int gotKind;
    vAdr       = va;
    accessType = acc;
    satpPpn    = RootPpn;
    tlbMiss    = 1'b1;
    @(negedge clk);
    while (!(tlbWrite || pageFault || accessFault)) @(negedge clk);
    tlbMiss = 1'b0;  // Requester drops the miss on the result
    gotKind = tlbWrite ? KindWrite : (pageFault ? KindPage : KindAccess);
    assert ($onehot({tlbWrite, pageFault, accessFault}))
      else stopRun($sformatf("Several result pulses at once in %s", testName));
    assert (gotKind == expKind) else failValue("result", 64'(expKind), 64'(gotKind));
    if (expKind == KindWrite) begin
      assert (pte == expPte) else failValue("pte", expPte, pte);
      assert (pageType == expType) else failValue("pageType", 64'(expType), 64'(pageType));
    end
    assert (expAdr.size() == 0)
      else stopRun($sformatf("Walk in %s ended before all table reads", testName));
    @(negedge clk);
    assert (!busy && !(tlbWrite || pageFault || accessFault))
      else stopRun($sformatf("Walker not idle after the result in %s", testName));
  endtask

  // Random VA and PPN, entry with the given flags at level lvl
  task automatic walkTo(input string name, input int lvl, input logic [7:0] flags,
                        input accessType_t acc, input logic misalign);
    logic [63:0] va;
    logic [43:0] ppn;
    testName = name;
    va  = makeVa(39'(takeBits(39)));
    ppn = 44'(takeBits(44));
    ppn = ppn & ~((44'd1 << (9 * lvl)) - 44'd1);  // Superpage aligned
    if (misalign) ppn[0] = 1'b1;
    buildWalk(va, lvl, makePte(ppn, flags), acc);
    runWalk(va, acc);
  endtask

  task automatic runSuite();
    logic [63:0] va;
    walkTo("kilopage", 0, 8'hCF, accLoad, 1'b0);
    walkTo("megapage", 1, 8'hCF, accLoad, 1'b0);
    walkTo("gigapage", 2, 8'hCF, accLoad, 1'b0);
    // Permission and A/D
    walkTo("load no R", 0, 8'h49, accLoad, 1'b0);
    walkTo("store no W", 1, 8'hC3, accStore, 1'b0);
    walkTo("fetch no X", 2, 8'hC7, accFetch, 1'b0);
    walkTo("load A clear", 0, 8'h8B, accLoad, 1'b0);
    walkTo("store D clear", 1, 8'h47, accStore, 1'b0);
    walkTo("load ok", 2, 8'h43, accLoad, 1'b0);
    walkTo("store ok", 0, 8'hC7, accStore, 1'b0);
    walkTo("fetch ok", 1, 8'h49, accFetch, 1'b0);
    // Structural faults
    walkTo("V clear", 1, 8'h00, accLoad, 1'b0);
    walkTo("W without R", 0, 8'hC5, accStore, 1'b0);
    walkTo("pointer reserved", 2, 8'h41, accLoad, 1'b0);
    walkTo("pointer level 0", 0, 8'h01, accLoad, 1'b0);
    walkTo("misaligned mega", 1, 8'hCF, accLoad, 1'b1);
    walkTo("misaligned giga", 2, 8'hCF, accFetch, 1'b1);
    testName = "non canonical";
    va = makeVa(39'(takeBits(39))) ^ (64'd1 << 50);
    buildWalk(va, 0, makePte(44'h123, 8'hCF), accLoad);
    runWalk(va, accLoad);
    testName = "access fault";  // Bus error on the level 1 read
    va = makeVa(39'(takeBits(39)));
    buildWalk(va, 0, makePte(44'h456, 8'hCF), accLoad);
    breakRead(1);
    runWalk(va, accLoad);
  endtask

  initial begin
    logic [63:0] va;
    arstN      = 1'b0;
    flush      = 1'b0;
    tlbMiss    = 1'b0;
    vAdr       = '0;
    satpPpn    = RootPpn;
    accessType = accLoad;
    faultArmed = 1'b0;
    faultAdr   = '0;
    stallOn    = 1'b0;
    repeat (10) @(negedge clk);
    assert (!memRead && !busy && !tlbWrite && !pageFault && !accessFault)
      else stopRun("Outputs not idle in reset");
    arstN = 1'b1;
    @(negedge clk);
    runSuite();
    stallOn = 1'b1;  // Same walks, random stalls on every read
    runSuite();
    testName = "flush";
    va = makeVa(39'(takeBits(39)));
    buildWalk(va, 0, makePte(44'h789, 8'hCF), accLoad);
    vAdr       = va;
    accessType = accLoad;
    tlbMiss    = 1'b1;
    @(negedge clk);
    while (!memRead) @(negedge clk);
    flush   = 1'b1;  // Abandon in the middle of a read
    tlbMiss = 1'b0;
    @(negedge clk);
    flush = 1'b0;
    assert (!busy) else stopRun("Walker still busy after flush");
    @(negedge clk);
    walkTo("after flush", 0, 8'hCF, accStore, 1'b0);
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/ptw.sv
// Sv39 hardware page table walker top level
// Walker FSM with address generator and entry checker side by side
`default_nettype none

module ptw import ptwPkg::*; #(
  parameter int PaBits = 56  // Physical address width, 32..56
) (
  input  logic               clk,
  input  logic               arstN,
  input  logic               flush,
  input  logic               tlbMiss,
  input  logic               memStall,
  input  logic               memAccessFault,
  input  logic [PteBits-1:0] vAdr,
  input  logic [PteBits-1:0] memRdData,
  input  logic [PpnBits-1:0] satpPpn,
  input  accessType_t        accessType,
  output logic [PaBits-1:0]  memAdr,
  output logic               memRead,
  output logic               busy,
  output logic               tlbWrite,
  output logic               pageFault,
  output logic               accessFault,
  output logic [PteBits-1:0] pte,
  output level_t             pageType
);

  level_t level;         // Current walk level
  logic   nonCanonical;  // Bad upper VA bits
  logic   leaf;          // Captured entry is a leaf
  logic   pteFault;      // Captured entry breaks a rule

  ////////////////////
  // Datapath helpers
  ////////////////////
  ptwAddrGen #(.PaBits(PaBits)) addrGen (
    .vAdr        (vAdr),
    .satpPpn     (satpPpn),
    .pte         (pte),
    .level       (level),
    .memAdr      (memAdr),
    .nonCanonical(nonCanonical)
  );

  ptwPteCheck pteCheck (
    .pte       (pte),
    .level     (level),
    .accessType(accessType),
    .leaf      (leaf),
    .pageFault (pteFault)
  );

  // Sequencing and result strobes
  ptwWalker #(.PaBits(PaBits)) walker (
    .clk           (clk),
    .arstN         (arstN),
    .flush         (flush),
    .tlbMiss       (tlbMiss),
    .memStall      (memStall),
    .memAccessFault(memAccessFault),
    .memRdData     (memRdData),
    .nonCanonical  (nonCanonical),
    .leaf          (leaf),
    .pageFault     (pteFault),
    .level         (level),
    .pte           (pte),
    .memRead       (memRead),
    .busy          (busy),
    .tlbWrite      (tlbWrite),
    .pageFaultOut  (pageFault),
    .accessFault   (accessFault),
    .pageType      (pageType)
  );

endmodule

`default_nettype wire

// File: hw/ptwWalker.sv
// Sv39 walk FSM
// Entry register, level register, fault kind and the result strobes
`default_nettype none

module ptwWalker import ptwPkg::*; #(
  parameter int PaBits = 56  // Same width as the address generator
) (
  input  logic               clk,
  input  logic               arstN,
  input  logic               flush,
  input  logic               tlbMiss,
  input  logic               memStall,
  input  logic               memAccessFault,
  input  logic [PteBits-1:0] memRdData,
  input  logic               nonCanonical,   // From address generator
  input  logic               leaf,           // From entry checker
  input  logic               pageFault,      // From entry checker
  output level_t             level,
  output logic [PteBits-1:0] pte,
  output logic               memRead,
  output logic               busy,
  output logic               tlbWrite,
  output logic               pageFaultOut,
  output logic               accessFault,
  output level_t             pageType
);

  localparam level_t TopLevel = level_t'(Levels - 1);  // Sv39 starts at level 2

  walkState_t state, stateNext;
  logic       startWalk;
  logic       rdDone;         // Read answered this cycle
  logic       faultIsAccess;  // Fault kind, memory vs page check
  logic       descend;        // Pointer entry, go one level down

  assign startWalk = (state == stIdle) & tlbMiss;
  assign rdDone    = (state == stRd) & ~memStall;
  assign descend   = (state == stCheck) & ~pageFault & ~leaf;

  ////////////////////
  // Next state
  ////////////////////
  always_comb begin
    stateNext = state;
    case (state)
      stIdle:  if (tlbMiss) stateNext = stAdr;
      stAdr:   stateNext = nonCanonical ? stFault : stRd;
      stRd: begin
        if (!memStall) begin
          stateNext = memAccessFault ? stFault : stCheck;  // Bus error beats entry check
        end
      end
      stCheck: begin
        if (pageFault) stateNext = stFault;
        else if (leaf) stateNext = stLeaf;
        else stateNext = stAdr;                            // Next level down
      end
      stLeaf:  stateNext = stIdle;
      stFault: stateNext = stIdle;
      default: stateNext = stIdle;
    endcase
    if (flush) stateNext = stIdle;  // Abandon walk, no result
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= stIdle;
    end else begin
      state <= stateNext;
    end
  end

  ////////////////////
  // Level and fault kind
  ////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      level         <= TopLevel;
      faultIsAccess <= 1'b0;
    end else begin
      if (startWalk) level <= TopLevel;
      else if (descend) level <= level - 2'd1;  // Checker faults a pointer at level 0
      if (rdDone) faultIsAccess <= memAccessFault;
      else if (state == stAdr) faultIsAccess <= 1'b0;  // Non-canonical is a page fault
    end
  end

  // Entry register, loaded when the read completes
  always_ff @(posedge clk) begin
    if (rdDone) pte <= memRdData;
  end

  ////////////////////
  // Outputs
  ////////////////////
  assign memRead      = (state == stRd);
  assign busy         = (state != stIdle);
  assign tlbWrite     = (state == stLeaf) & ~flush;
  assign pageFaultOut = (state == stFault) & ~faultIsAccess & ~flush;
  assign accessFault  = (state == stFault) & faultIsAccess & ~flush;
  assign pageType     = level;  // Level of the leaf, held through stLeaf

endmodule

`default_nettype wire

// File: hw/ptwPteCheck.sv
// Page table entry decode
// Leaf detection and all Sv39 page fault rules for one level
`default_nettype none

module ptwPteCheck import ptwPkg::*; (
  input  logic [PteBits-1:0] pte,
  input  level_t             level,
  input  accessType_t        accessType,
  output logic               leaf,
  output logic               pageFault
);

  // Entry fields
  logic       pteV, pteR, pteW, pteX, pteU, pteA, pteD;
  logic [1:0] ptePbmt;

  logic invalid;          // V clear or W without R
  logic nonLeaf;          // Valid pointer to the next table
  logic reservedFault;    // D, A, U or PBMT set on a pointer
  logic bottomFault;      // Pointer found at level 0
  logic misaligned;       // Superpage with nonzero low PPN fields
  logic permFault;        // Missing R, W or X for the access
  logic adFault;          // A clear, or D clear on a store
  logic leafFault;

  assign {pteD, pteA} = pte[7:6];
  assign pteU    = pte[4];
  assign {pteX, pteW, pteR, pteV} = pte[3:0];
  assign ptePbmt = pte[62:61];

  ////////////////////
  // Entry class
  ////////////////////
  assign leaf    = pteV & (pteR | pteW | pteX);
  assign invalid = ~pteV | (pteW & ~pteR);
  assign nonLeaf = pteV & ~(pteR | pteW | pteX);

  // Reserved bits on a pointer entry
  assign reservedFault = nonLeaf & (pteD | pteA | pteU | (|ptePbmt));
  assign bottomFault   = nonLeaf & (level == 2'd0);  // No table below level 0

  ////////////////////
  // Leaf rules
  ////////////////////
  always_comb begin
    case (level)
      2'd2:    misaligned = |pte[27:10];  // PPN1 and PPN0 must be zero
      2'd1:    misaligned = |pte[18:10];  // PPN0 must be zero
      default: misaligned = 1'b0;         // Kilopage always aligned
    endcase
  end

  always_comb begin
    case (accessType)
      accLoad:  permFault = ~pteR;
      accStore: permFault = ~pteW;
      default:  permFault = ~pteX;        // Instruction fetch
    endcase
  end

  // A and D are maintained by software, hardware only checks them
  assign adFault = ~pteA | ((accessType == accStore) & ~pteD);

  assign leafFault = leaf & (misaligned | permFault | adFault);

  assign pageFault = invalid | reservedFault | bottomFault | leafFault;

endmodule

`default_nettype wire

// File: hw/ptwAddrGen.sv
// Table read address for the current walk level
// Canonical check of the virtual address
`default_nettype none

module ptwAddrGen import ptwPkg::*; #(
  parameter int PaBits = 56  // Physical address width, 32..56
) (
  input  logic [PteBits-1:0] vAdr,
  input  logic [PpnBits-1:0] satpPpn,
  input  logic [PteBits-1:0] pte,      // Entry register, next table pointer
  input  level_t             level,
  output logic [PaBits-1:0]  memAdr,
  output logic               nonCanonical
);

  localparam int FullBits = PpnBits + VpnBits + 3;  // Full 56 bit entry address

  logic [PpnBits-1:0]  basePpn;  // Table base for this level
  logic [VpnBits-1:0]  vpn;      // VPN field indexing the table
  logic [FullBits-1:0] fullAdr;

  ////////////////////
  // Table address
  ////////////////////
  assign basePpn = (level == 2'd2) ? satpPpn : pte[PpnBits+9:10];  // Root table at level 2

  always_comb begin
    case (level)
      2'd2:    vpn = vAdr[PageOffsetBits + 2 * VpnBits +: VpnBits];  // VPN2
      2'd1:    vpn = vAdr[PageOffsetBits + VpnBits +: VpnBits];      // VPN1
      default: vpn = vAdr[PageOffsetBits +: VpnBits];                // VPN0
    endcase
  end

  // Eight byte entries
  assign fullAdr = {basePpn, vpn, 3'b000};
  assign memAdr  = fullAdr[PaBits-1:0];  // Upper bits dropped on narrow systems

  // Bits 63..39 must copy bit 38
  assign nonCanonical = (vAdr[PteBits-1:VaBits] != {(PteBits-VaBits){vAdr[VaBits-1]}});

endmodule

`default_nettype wire

// File: hw/ptwPkg.sv
// Sv39 page table walker shared definitions
// Entry and address widths, level numbering, access and walker state encodings
`default_nettype none

package ptwPkg;

  ////////////////////
  // Sv39 geometry
  ////////////////////
  localparam int PteBits        = 64;  // Entry width, also the VA register width
  localparam int PageOffsetBits = 12;  // 4 KiB base page
  localparam int VpnBits        = 9;   // One VPN field
  localparam int Levels         = 3;   // Sv39 has three table levels
  localparam int VaBits         = 39;  // Bits above 38 are sign copies
  localparam int PpnBits        = 44;  // Entry bits 53..10

  // Level number, doubles as page type
  // 2 = gigapage, 1 = megapage, 0 = kilopage
  typedef logic [1:0] level_t;

  // Kind of access that missed in the TLB
  typedef enum logic [1:0] {
    accFetch = 2'd0,
    accLoad  = 2'd1,
    accStore = 2'd2
  } accessType_t;

  ////////////////////
  // Walker FSM
  ////////////////////
  typedef enum logic [2:0] {
    stIdle  = 3'd0,  // Waiting for a miss
    stAdr   = 3'd1,  // Table address formed, canonical check
    stRd    = 3'd2,  // Memory read in flight
    stCheck = 3'd3,  // Captured entry decoded
    stLeaf  = 3'd4,  // TLB write strobe
    stFault = 3'd5   // Fault pulse
  } walkState_t;

endpackage

`default_nettype wire
